// ==== tb.f ====
source/vect_pkg.sv
source/vect_res_if.sv
source/fx_lane.sv
source/vect_addmul_pipe.sv
source/res_fifo.sv
source/vect_addmul.sv
bench/vect_addmul_props.sv
bench/vect_addmul_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with verilator, then look for the pass line in sim.log.
verilator --binary --timing --assert -Wno-fatal --top-module vect_addmul_tb -f tb.f \
    -o vect_addmul_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/vect_addmul_sim > sim.log 2>&1
grep -qx '\*\* PASS \*\*' sim.log && echo "simulation passed" ||
    { echo "simulation failed, see sim.log"; exit 1; }

// ==== bench/vect_addmul_tb.sv ====
module vect_addmul_tb
    import vect_pkg::*;
();

    localparam int TIMEOUT = 2000; // about ten times the length of all tests.
    localparam int EXP_W   = LANES*WIDTH + LANES + TAG_W;

    logic clk_i   = 1'b0;
    logic rst_n_i = 1'b0;
    logic clear_i = 1'b0, round_mode_i = 1'b0, op_mul_i = 1'b0;
    logic op_mod_add_i = 1'b0, op_mod_mul_i = 1'b0;
    logic add_valid_i = 1'b0, add_scal_valid_i = 1'b1, add_ready_i = 1'b1;
    logic mul_valid_i = 1'b0, mul_scal_valid_i = 1'b1, mul_ready_i = 1'b1;
    logic [LANES-1:0]            add_strb_i = '0, mul_strb_i = '0;
    logic [LANES-1:0][WIDTH-1:0] add_vect_i = '0, mul_vect_i = '0;
    logic [WIDTH-1:0]            add_scal_i = '0, mul_scal_i = '0;
    logic [TAG_W-1:0]            add_tag_i = '0, mul_tag_i = '0;
    logic                        add_ready_o, mul_ready_o, add_valid_o, mul_valid_o;
    logic [LANES-1:0]            add_strb_o, mul_strb_o;
    logic [LANES-1:0][WIDTH-1:0] add_res_o, mul_res_o;
    logic [TAG_W-1:0]            add_tag_o, mul_tag_o;

    int              seed = 32'h97fa_c51e;
    int              cycle = 0;
    int              n_pass = 0;
    int              n_fail = 0;
    bit              check_lat = 1'b0;
    bit              pend_mul;
    logic [EXP_W-1:0] pend_word;
    logic [EXP_W-1:0] exp_q [2][$]; // index 0 is the add output, 1 the mul output.
    int              acc_q [2][$];

    vect_addmul i_dut (.*);

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (cycle == TIMEOUT) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT);
            $display("** FAIL **");
            $finish;
        end
    end

    // one lane of q8.8 arithmetic.
    function automatic logic [WIDTH-1:0] lane_model(input bit mul, input bit mod, input bit rnd,
            input logic [WIDTH-1:0] e, input logic [WIDTH-1:0] s);
        longint r;
        longint hi;
        hi = (longint'(1) <<< (WIDTH - 1)) - 1;
        if (mul) begin
            r = longint'($signed(e)) * longint'($signed(s));
            if (rnd) r = r + (longint'(1) <<< (FRAC - 1)); // ties go up.
            r = r >>> FRAC;
            if (mod) r = -r;
        end else begin
            r = mod ? longint'($signed(e)) - longint'($signed(s))
                    : longint'($signed(e)) + longint'($signed(s));
        end
        if (r > hi) r = hi;
        if (r < -hi - 1) r = -hi - 1;
        return r[WIDTH-1:0];
    endfunction

    function automatic logic [EXP_W-1:0] expect_word(input bit mul, input bit mod, input bit rnd,
            input logic [LANES-1:0] strb, input logic [LANES-1:0][WIDTH-1:0] v,
            input logic [WIDTH-1:0] s, input logic [TAG_W-1:0] tag);
        logic [LANES-1:0][WIDTH-1:0] r;
        for (int l = 0; l < LANES; l++) begin
            r[l] = strb[l] ? lane_model(mul, mod, rnd, v[l], s) : '0;
        end
        return {r, strb, tag};
    endfunction

    function automatic logic [LANES-1:0][WIDTH-1:0] rand_vect();
        logic [LANES-1:0][WIDTH-1:0] v;
        for (int l = 0; l < LANES; l++) begin
            v[l] = $random(seed);
        end
        return v;
    endfunction

    task automatic fail(input string msg);
        $display("CHECK FAILED @%0t: %s", $time, msg);
        n_fail++;
    endtask

    // the other port carries inverted operands and must be ignored.
    task automatic drive(input bit mul, input bit mod, input bit rnd, input logic [LANES-1:0] strb,
            input logic [LANES-1:0][WIDTH-1:0] v, input logic [WIDTH-1:0] s,
            input logic [TAG_W-1:0] tag);
        @(negedge clk_i);
        {op_mul_i, round_mode_i} = {mul, rnd};
        if (mul) begin
            op_mod_mul_i = mod;
            op_mod_add_i = ~mod;
            {mul_strb_i, mul_vect_i, mul_scal_i, mul_tag_i} = {strb, v, s, tag};
            {add_strb_i, add_vect_i, add_scal_i, add_tag_i} = ~{strb, v, s, tag};
        end else begin
            op_mod_add_i = mod;
            op_mod_mul_i = ~mod;
            {add_strb_i, add_vect_i, add_scal_i, add_tag_i} = {strb, v, s, tag};
            {mul_strb_i, mul_vect_i, mul_scal_i, mul_tag_i} = ~{strb, v, s, tag};
        end
        {add_valid_i, mul_valid_i} = {~mul, mul};
        pend_mul  = mul;
        pend_word = expect_word(mul, mod, rnd, strb, v, s, tag);
    endtask

    task automatic wait_accept();
        do begin
            @(posedge clk_i);
        end while (!(pend_mul ? mul_valid_i && mul_ready_o : add_valid_i && add_ready_o));
        exp_q[pend_mul].push_back(pend_word);
        acc_q[pend_mul].push_back(cycle);
    endtask

    task automatic send(input bit mul, input bit mod, input bit rnd, input logic [LANES-1:0] strb,
            input logic [LANES-1:0][WIDTH-1:0] v, input logic [WIDTH-1:0] s,
            input logic [TAG_W-1:0] tag);
        drive(mul, mod, rnd, strb, v, s, tag);
        wait_accept();
    endtask

    task automatic idle();
        @(negedge clk_i);
        {add_valid_i, mul_valid_i} = 2'b00;
    endtask

    task automatic wait_empty();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            @(posedge clk_i);
        end
    endtask

    task automatic check_out(input bit mul, input logic [EXP_W-1:0] got);
        logic [EXP_W-1:0] want;
        int acc;
        if (exp_q[mul].size() == 0) begin
            $display("unexpected result on the %s output at time %0t", mul ? "mul" : "add", $time);
            n_fail++;
        end else begin
            want = exp_q[mul].pop_front();
            acc  = acc_q[mul].pop_front();
            assert (got === want) n_pass++;
            else fail($sformatf("%s output got %h, expected %h", mul ? "mul" : "add", got, want));
            if (check_lat) begin
                assert (cycle - acc == 3) n_pass++;
                else fail($sformatf("result took %0d cycles, expected 3", cycle - acc));
            end
        end
    endtask

    always @(posedge clk_i) begin
        if (rst_n_i && add_valid_o && add_ready_i) begin
            check_out(1'b0, {add_res_o, add_strb_o, add_tag_o});
        end
        if (rst_n_i && mul_valid_o && mul_ready_i) begin
            check_out(1'b1, {mul_res_o, mul_strb_o, mul_tag_o});
        end
    end

    task automatic report(input string name, input int f0);
        if (n_fail == f0) $display("%s: ok", name);
        else $display("%s: %0d failed checks", name, n_fail - f0);
    endtask

    task automatic test_add_sub();
        int f0;
        f0 = n_fail;
        check_lat = 1'b1;
        for (int i = 0; i < 8; i++) begin
            send(1'b0, i >= 4, 1'b0, '1, rand_vect(), $random(seed), i);
        end
        send(1'b0, 1'b0, 1'b0, '1, {LANES{16'h7f00}}, 16'h4000, 4'hf); // 127 + 64 saturates.
        idle();
        wait_empty();
        check_lat = 1'b0;
        report("add and subtract", f0);
    endtask

    task automatic test_mul();
        int f0;
        f0 = n_fail;
        for (int r = 0; r < 2; r++) begin
            for (int m = 0; m < 2; m++) begin
                for (int i = 0; i < 3; i++) begin
                    send(1'b1, m[0], r[0], '1, rand_vect(), $random(seed) % 1024, i);
                end
                send(1'b1, m[0], r[0], '1, {LANES{16'h4000}}, 16'h0800, 4'he); // 64 * 8.
            end
        end
        idle();
        wait_empty();
        report("multiply", f0);
    endtask

    task automatic test_strobes();
        int f0;
        f0 = n_fail;
        for (int i = 0; i < 8; i++) begin
            send(i[0], 1'b0, 1'b1, (i == 0) ? 0 : $random(seed), rand_vect(),
                 $random(seed) % 512, i);
        end
        idle();
        wait_empty();
        report("strobes", f0);
    endtask

    task automatic test_backpressure();
        int f0;
        f0 = n_fail;
        @(negedge clk_i);
        add_ready_i = 1'b0;
        for (int i = 0; i < ADD_FIFO_DEPTH + PIPE_STAGES; i++) begin
            send(1'b0, 1'b0, 1'b0, '1, rand_vect(), $random(seed), i);
        end
        drive(1'b0, 1'b1, 1'b0, '1, rand_vect(), $random(seed), 4'hc); // one too many.
        repeat (4) begin
            @(posedge clk_i);
            assert (!add_ready_o) n_pass++;
            else fail("add_ready_o high while queue and pipeline are full");
        end
        @(negedge clk_i);
        add_ready_i = 1'b1;
        wait_accept();
        idle();
        wait_empty();
        report("back-pressure", f0);
    endtask

    task automatic test_interleave();
        int f0;
        f0 = n_fail;
        for (int i = 0; i < 10; i++) begin
            send(i[0], $random(seed), 1'b0, '1, rand_vect(), $random(seed) % 1024, i);
        end
        idle();
        wait_empty();
        report("interleaving", f0);
    endtask

    task automatic test_clear();
        int f0;
        f0 = n_fail;
        @(negedge clk_i);
        add_ready_i = 1'b0;
        mul_ready_i = 1'b0;
        for (int i = 0; i < ADD_FIFO_DEPTH; i++) begin
            send(1'b0, 1'b0, 1'b0, '1, rand_vect(), $random(seed), i);
        end
        for (int i = 0; i < MUL_FIFO_DEPTH; i++) begin
            send(1'b1, 1'b0, 1'b0, '1, rand_vect(), $random(seed) % 1024, i);
        end
        idle();
        repeat (4) @(posedge clk_i);
        assert (add_valid_o && mul_valid_o) n_pass++;
        else fail("result queues did not fill before the clear");
        @(negedge clk_i);
        clear_i = 1'b1;
        for (int p = 0; p < 2; p++) begin
            exp_q[p].delete();
            acc_q[p].delete();
        end
        @(negedge clk_i);
        clear_i = 1'b0;
        assert (!add_valid_o && !mul_valid_o) n_pass++;
        else fail("output valids still high one cycle after clear");
        add_ready_i = 1'b1;
        mul_ready_i = 1'b1;
        send(1'b0, 1'b1, 1'b0, '1, rand_vect(), $random(seed), 4'h9);
        idle();
        wait_empty();
        report("clear", f0);
    endtask

    initial begin
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        test_add_sub();
        test_mul();
        test_strobes();
        test_backpressure();
        test_interleave();
        test_clear();
        repeat (4) @(posedge clk_i); // catch stray results.
        $display("checks passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== bench/vect_addmul_props.sv ====
module vect_addmul_props
    import vect_pkg::*;
(
    input logic                        clk_i,
    input logic                        rst_n_i,
    input logic                        clear_i,
    input logic                        add_ready_o,
    input logic                        mul_ready_o,
    input logic                        add_valid_o,
    input logic                        add_ready_i,
    input logic [LANES-1:0]            add_strb_o,
    input logic [LANES-1:0][WIDTH-1:0] add_res_o,
    input logic [TAG_W-1:0]            add_tag_o,
    input logic                        mul_valid_o,
    input logic                        mul_ready_i,
    input logic [LANES-1:0]            mul_strb_o,
    input logic [LANES-1:0][WIDTH-1:0] mul_res_o,
    input logic [TAG_W-1:0]            mul_tag_o
);

    // only one operand port is ready at a time.
    assert property (@(posedge clk_i) disable iff (!rst_n_i) !(add_ready_o && mul_ready_o))
    else $error("add_ready_o and mul_ready_o high together");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        add_valid_o && !add_ready_i && !clear_i |=>
            add_valid_o && $stable({add_res_o, add_strb_o, add_tag_o}))
    else $error("add output dropped or changed while stalled");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mul_valid_o && !mul_ready_i && !clear_i |=>
            mul_valid_o && $stable({mul_res_o, mul_strb_o, mul_tag_o}))
    else $error("mul output dropped or changed while stalled");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        clear_i |=> !add_valid_o && !mul_valid_o)
    else $error("output valid high after clear");

endmodule

bind vect_addmul vect_addmul_props i_props (.*);

// ==== source/vect_addmul.sv ====
module vect_addmul
    import vect_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        clear_i,
    input  logic                        round_mode_i,
    input  logic                        op_mul_i,
    input  logic                        op_mod_add_i,
    input  logic                        op_mod_mul_i,

    input  logic                        add_valid_i,
    input  logic                        add_scal_valid_i,
    input  logic [LANES-1:0]            add_strb_i,
    input  logic [LANES-1:0][WIDTH-1:0] add_vect_i,
    input  logic [WIDTH-1:0]            add_scal_i,
    input  logic [TAG_W-1:0]            add_tag_i,
    output logic                        add_ready_o,

    input  logic                        mul_valid_i,
    input  logic                        mul_scal_valid_i,
    input  logic [LANES-1:0]            mul_strb_i,
    input  logic [LANES-1:0][WIDTH-1:0] mul_vect_i,
    input  logic [WIDTH-1:0]            mul_scal_i,
    input  logic [TAG_W-1:0]            mul_tag_i,
    output logic                        mul_ready_o,

    input  logic                        add_ready_i,
    output logic                        add_valid_o,
    output logic [LANES-1:0]            add_strb_o,
    output logic [LANES-1:0][WIDTH-1:0] add_res_o,
    output logic [TAG_W-1:0]            add_tag_o,

    input  logic                        mul_ready_i,
    output logic                        mul_valid_o,
    output logic [LANES-1:0]            mul_strb_o,
    output logic [LANES-1:0][WIDTH-1:0] mul_res_o,
    output logic [TAG_W-1:0]            mul_tag_o
);

    logic                           sel_valid;
    logic                           sel_mod;
    logic [LANES-1:0]               sel_strb;
    logic [LANES-1:0][WIDTH-1:0]    sel_vect;
    logic [TAG_W-1:0]               sel_tag;
    logic                           pipe_ready;

    vect_res_if add_res_if ();
    vect_res_if mul_res_if ();

    // operand port picked by the operation bit.
    assign sel_valid = op_mul_i ? mul_valid_i & mul_scal_valid_i : add_valid_i & add_scal_valid_i;
    assign sel_mod   = op_mul_i ? op_mod_mul_i : op_mod_add_i;
    assign sel_strb  = op_mul_i ? mul_strb_i : add_strb_i;
    assign sel_vect  = op_mul_i ? mul_vect_i : add_vect_i;
    assign sel_tag   = op_mul_i ? mul_tag_i : add_tag_i;

    assign add_ready_o = ~op_mul_i & add_scal_valid_i & pipe_ready;
    assign mul_ready_o = op_mul_i & mul_scal_valid_i & pipe_ready;

    vect_addmul_pipe i_pipe (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .clear_i      (clear_i),
        .round_mode_i (round_mode_i),
        .op_mul_i     (op_mul_i),
        .op_mod_i     (sel_mod),
        .in_valid_i   (sel_valid),
        .in_strb_i    (sel_strb),
        .in_vect_i    (sel_vect),
        .mul_scal_i   (mul_scal_i), // scalars broadcast as is.
        .add_scal_i   (add_scal_i),
        .in_tag_i     (sel_tag),
        .in_ready_o   (pipe_ready),
        .add_res      (add_res_if.master),
        .mul_res      (mul_res_if.master)
    );

    res_fifo #(
        .DEPTH (ADD_FIFO_DEPTH)
    ) i_add_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .clear_i (clear_i),
        .in      (add_res_if.slave),
        .valid_o (add_valid_o),
        .ready_i (add_ready_i),
        .strb_o  (add_strb_o),
        .data_o  (add_res_o),
        .tag_o   (add_tag_o)
    );

    res_fifo #(
        .DEPTH (MUL_FIFO_DEPTH)
    ) i_mul_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .clear_i (clear_i),
        .in      (mul_res_if.slave),
        .valid_o (mul_valid_o),
        .ready_i (mul_ready_i),
        .strb_o  (mul_strb_o),
        .data_o  (mul_res_o),
        .tag_o   (mul_tag_o)
    );

endmodule

// ==== source/res_fifo.sv ====
module res_fifo
    import vect_pkg::*;
#(
    parameter int unsigned DEPTH = ADD_FIFO_DEPTH
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        clear_i,
    vect_res_if.slave                   in,
    output logic                        valid_o,
    input  logic                        ready_i,
    output logic [LANES-1:0]            strb_o,
    output logic [LANES-1:0][WIDTH-1:0] data_o,
    output logic [TAG_W-1:0]            tag_o
);

    logic [LANES-1:0][WIDTH-1:0]    data_mem [DEPTH];
    logic [LANES-1:0]               strb_mem [DEPTH];
    logic [TAG_W-1:0]               tag_mem  [DEPTH];
    logic [$clog2(DEPTH)-1:0]       wr_ptr;
    logic [$clog2(DEPTH)-1:0]       rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]     count;
    logic                           push;
    logic                           pop;

    assign in.ready = (count != DEPTH); // not full.
    assign valid_o  = (count != 0);

    assign push = in.valid & in.ready;
    assign pop  = valid_o & ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            data_mem[wr_ptr] <= in.data;
            strb_mem[wr_ptr] <= in.strb;
            tag_mem[wr_ptr]  <= in.tag;
        end
    end

    // head is registered storage, so a push shows one cycle later.
    assign data_o = data_mem[rd_ptr];
    assign strb_o = strb_mem[rd_ptr];
    assign tag_o  = tag_mem[rd_ptr];

endmodule

// ==== source/vect_addmul_pipe.sv ====
module vect_addmul_pipe
    import vect_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        clear_i,
    input  logic                        round_mode_i,
    input  logic                        op_mul_i,
    input  logic                        op_mod_i,
    input  logic                        in_valid_i,
    input  logic [LANES-1:0]            in_strb_i,
    input  logic [LANES-1:0][WIDTH-1:0] in_vect_i,
    input  logic [WIDTH-1:0]            mul_scal_i,
    input  logic [WIDTH-1:0]            add_scal_i,
    input  logic [TAG_W-1:0]            in_tag_i,
    output logic                        in_ready_o,
    vect_res_if.master                  add_res,
    vect_res_if.master                  mul_res
);

    logic [LANES-1:0][WIDTH-1:0]    res_d;
    logic [PIPE_STAGES-1:0]         vld_q;
    logic [PIPE_STAGES-1:0]         op_q;
    logic [PIPE_STAGES-1:0]         stage_rdy;
    logic [LANES-1:0][WIDTH-1:0]    res_q  [PIPE_STAGES];
    logic [LANES-1:0]               strb_q [PIPE_STAGES];
    logic [TAG_W-1:0]               tag_q  [PIPE_STAGES];
    logic                           out_ready;

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        fx_lane i_lane (
            .op_mul_i     (op_mul_i),
            .op_mod_i     (op_mod_i),
            .round_mode_i (round_mode_i),
            .strb_i       (in_strb_i[l]),
            .vect_i       (in_vect_i[l]),
            .mul_scal_i   (mul_scal_i),
            .add_scal_i   (add_scal_i),
            .res_o        (res_d[l])
        );
    end

    // the last stage waits on the queue its operation bit names.
    assign out_ready = op_q[PIPE_STAGES-1] ? mul_res.ready : add_res.ready;

    always_comb begin
        stage_rdy[PIPE_STAGES-1] = ~vld_q[PIPE_STAGES-1] | out_ready;
        for (int s = PIPE_STAGES - 2; s >= 0; s--) begin
            stage_rdy[s] = ~vld_q[s] | stage_rdy[s+1]; // empty or moving.
        end
    end

    assign in_ready_o = stage_rdy[0];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else if (clear_i) begin
            vld_q <= '0; // flush.
        end else begin
            if (stage_rdy[0]) vld_q[0] <= in_valid_i;
            for (int s = 1; s < PIPE_STAGES; s++) begin
                if (stage_rdy[s]) vld_q[s] <= vld_q[s-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_rdy[0] && in_valid_i) begin
            res_q[0]  <= res_d;
            strb_q[0] <= in_strb_i;
            tag_q[0]  <= in_tag_i;
            op_q[0]   <= op_mul_i;
        end
        for (int s = 1; s < PIPE_STAGES; s++) begin
            if (stage_rdy[s] && vld_q[s-1]) begin
                res_q[s]  <= res_q[s-1];
                strb_q[s] <= strb_q[s-1];
                tag_q[s]  <= tag_q[s-1];
                op_q[s]   <= op_q[s-1];
            end
        end
    end

    assign add_res.valid = vld_q[PIPE_STAGES-1] & ~op_q[PIPE_STAGES-1];
    assign add_res.data  = res_q[PIPE_STAGES-1];
    assign add_res.strb  = strb_q[PIPE_STAGES-1];
    assign add_res.tag   = tag_q[PIPE_STAGES-1];

    assign mul_res.valid = vld_q[PIPE_STAGES-1] & op_q[PIPE_STAGES-1];
    assign mul_res.data  = res_q[PIPE_STAGES-1];
    assign mul_res.strb  = strb_q[PIPE_STAGES-1];
    assign mul_res.tag   = tag_q[PIPE_STAGES-1];

endmodule

// ==== source/fx_lane.sv ====
module fx_lane
    import vect_pkg::*;
(
    input  logic                op_mul_i,
    input  logic                op_mod_i,
    input  logic                round_mode_i,
    input  logic                strb_i,
    input  logic [WIDTH-1:0]    vect_i,
    input  logic [WIDTH-1:0]    mul_scal_i,
    input  logic [WIDTH-1:0]    add_scal_i,
    output logic [WIDTH-1:0]    res_o
);

    logic signed [WIDTH-1:0]    elem;
    logic signed [WIDTH-1:0]    m_scal;
    logic signed [WIDTH-1:0]    a_scal;
    logic signed [WIDTH:0]      sum;
    logic signed [2*WIDTH-1:0]  prod;
    logic signed [2*WIDTH:0]    half;
    logic signed [2*WIDTH:0]    prod_r;
    logic signed [2*WIDTH:0]    scaled;
    logic signed [2*WIDTH:0]    wide;
    logic [WIDTH-1:0]           sat;

    assign elem   = vect_i;
    assign m_scal = mul_scal_i;
    assign a_scal = add_scal_i;

    assign sum  = op_mod_i ? elem - a_scal : elem + a_scal; // one extra bit, no wrap.
    assign prod = elem * m_scal;

    always_comb begin
        half   = round_mode_i ? ((2*WIDTH+1)'(1) <<< (FRAC - 1)) : '0;
        prod_r = prod + half;
        scaled = prod_r >>> FRAC; // floor after the optional half.
        if (op_mul_i) begin
            wide = op_mod_i ? -scaled : scaled;
        end else begin
            wide = sum;
        end
    end

    // fits when every bit above the result sign matches it.
    always_comb begin
        if (&wide[2*WIDTH:WIDTH-1] || ~|wide[2*WIDTH:WIDTH-1]) begin
            sat = wide[WIDTH-1:0];
        end else if (wide[2*WIDTH]) begin
            sat = {1'b1, {(WIDTH-1){1'b0}}};
        end else begin
            sat = {1'b0, {(WIDTH-1){1'b1}}};
        end
    end

    assign res_o = strb_i ? sat : '0; // masked lanes read zero.

endmodule

// ==== source/vect_res_if.sv ====
interface vect_res_if
    import vect_pkg::*;
();

    logic                           valid;
    logic                           ready;
    logic [LANES-1:0][WIDTH-1:0]    data;
    logic [LANES-1:0]               strb;
    logic [TAG_W-1:0]               tag;

    // producer side, the pipeline.
    modport master (
        output valid,
        output data,
        output strb,
        output tag,
        input  ready
    );

    modport slave (
        input  valid,
        input  data,
        input  strb,
        input  tag,
        output ready
    );

endinterface

// ==== source/vect_pkg.sv ====
package vect_pkg;

    // vector geometry.
    localparam int unsigned LANES = 4;
    localparam int unsigned WIDTH = 16;

    // q8.8 fixed point.
    localparam int unsigned FRAC = 8;

    localparam int unsigned TAG_W = 4;

    // register stages between the lanes and the result queues.
    localparam int unsigned PIPE_STAGES = 2;

    localparam int unsigned ADD_FIFO_DEPTH = 4;
    localparam int unsigned MUL_FIFO_DEPTH = 2;

endpackage
